// File: Makefile
# Verilator simulation of the Reuleaux triangle drawer
VERILATOR ?= verilator
TOP       ?= reuleaux_tb
FILELIST  ?= files.f
BUILD_DIR ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Something failed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# a crashed or stopped run counts as a failure in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
logic/reuleaux_types_pkg.sv
logic/reuleaux_geom_pkg.sv
logic/reuleaux_ctrl.sv
logic/screen_clear.sv
logic/circle_octants.sv
logic/arc_clip.sv
logic/reuleaux_top.sv
verif/reuleaux_chk.sv
verif/reuleaux_tb.sv

// File: logic/arc_clip.sv
`timescale 1ns/1ps

module arc_clip (
    input  logic                              vif,
    input  logic                              rst_n,
    input  logic                              group_valid,
    input  reuleaux_types_pkg::spoint_t [7:0] points,
    input  reuleaux_types_pkg::centre_t       group_arc,
    input  reuleaux_types_pkg::colour_t       colour,
    output logic                              ready,
    output reuleaux_types_pkg::pixel_t        pixel,
    output logic                              plot
);

    import reuleaux_types_pkg::*;
    import reuleaux_geom_pkg::*;

    spoint_t [7:0] pts_q;
    logic [7:0]    keep;
    logic [7:0]    mask_q;
    logic [2:0]    sel;
    logic          take;

    // on screen and on the visible part of this arc
    function automatic logic keep_point(input spoint_t p, input centre_t corner);
        logic on_screen;
        logic in_arc;
        on_screen = (p.x >= 0) && (p.x < SCREEN_W) && (p.y >= 0) && (p.y < SCREEN_H);
        case (corner.arc)
            // below the base line
            ARC_TOP_V:   in_arc = (p.y >= corner.y);
            // right of the apex, above the base
            ARC_LEFT_V:  in_arc = (p.x >= corner.x) && (p.y <= corner.y);
            ARC_RIGHT_V: in_arc = (p.x <= corner.x) && (p.y <= corner.y);
            default:     in_arc = 1'b0;
        endcase
        return on_screen && in_arc;
    endfunction

    // empty buffer accepts the next group
    assign ready = (mask_q == 8'd0);
    assign take  = group_valid && ready;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            keep[i] = keep_point(points[i], group_arc);
        end
    end

    // lowest surviving point goes first
    always_comb begin
        sel = '0;
        for (int i = 7; i >= 0; i--) begin
            if (mask_q[i]) sel = 3'(i);
        end
    end

    always_ff @(posedge vif or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= '0;
            plot   <= 1'b0;
        end else begin
            plot <= |mask_q;
            if (take) mask_q <= keep;
            else mask_q <= mask_q & ~(8'd1 << sel);
        end
    end

    // survivors are on screen, truncation is safe
    always_ff @(posedge vif) begin
        if (take) pts_q <= points;
        pixel <= '{x: xcoord_t'(pts_q[sel].x), y: ycoord_t'(pts_q[sel].y), colour: colour};
    end

endmodule

// File: logic/circle_octants.sv
`timescale 1ns/1ps

module circle_octants (
    input  logic                              vif,
    input  logic                              rst_n,
    input  logic                              arc_go,
    input  reuleaux_types_pkg::centre_t       arc_centre,
    input  reuleaux_types_pkg::diam_t         radius,
    input  logic                              ready,
    output logic                              group_valid,
    output reuleaux_types_pkg::spoint_t [7:0] points,
    output reuleaux_types_pkg::centre_t       group_arc,
    output logic                              arc_last
);

    import reuleaux_types_pkg::*;
    import reuleaux_geom_pkg::*;

    // a grows from 0, b shrinks from r, err is the midpoint decision
    diam_t              a_q;
    diam_t              b_q;
    diam_t              a_next;
    diam_t              b_next;
    logic signed [10:0] err_q;
    logic signed [10:0] err_next;
    logic               running;
    logic               finishing;
    logic               step;
    logic               stop;
    centre_t            ctr_q;
    centre_t            clip_ref;
    logic signed [15:0] cx;
    logic signed [15:0] cy;
    logic signed [15:0] oa;
    logic signed [15:0] ob;
    spoint_t [7:0]      pts;

    // far points pinned just off screen so the clipper drops them
    function automatic scoord_t clamp(input logic signed [15:0] v);
        if (v > 16'sd511) return scoord_t'(511);
        if (v < -16'sd512) return scoord_t'(-512);
        return scoord_t'(v);
    endfunction

    // advance while the output slot is free or being emptied
    assign step = running && (!group_valid || ready);
    assign stop = (a_q >= b_q) || (b_next < a_next);

    always_comb begin
        a_next = a_q + 8'd1;
        if (err_q < 0) begin
            b_next   = b_q;
            err_next = err_q + ($signed({3'b0, a_next}) <<< 1) + 11'sd1;
        end else begin
            b_next   = b_q - 8'd1;
            err_next = err_q + (($signed({3'b0, a_next}) - $signed({3'b0, b_next})) <<< 1)
                       + 11'sd1;
        end
    end

    // clip corner of this arc, base midpoint of the triangle
    always_comb begin
        clip_ref = arc_centre;
        case (arc_centre.arc)
            ARC_TOP_V:   clip_ref.y = arc_centre.y + 15'(3 * h1_of(radius));
            ARC_LEFT_V:  clip_ref.x = arc_centre.x + 15'(radius >> 1);
            ARC_RIGHT_V: clip_ref.x = arc_centre.x - 15'(radius >> 1);
            default:     clip_ref.arc = ARC_NONE;
        endcase
    end

    assign cx = 16'(ctr_q.x);
    assign cy = 16'(ctr_q.y);
    assign oa = $signed({8'b0, a_q});
    assign ob = $signed({8'b0, b_q});

    // eight mirror images of the current offset
    always_comb begin
        pts[0] = '{x: clamp(cx + ob), y: clamp(cy + oa)};
        pts[1] = '{x: clamp(cx + oa), y: clamp(cy + ob)};
        pts[2] = '{x: clamp(cx - oa), y: clamp(cy + ob)};
        pts[3] = '{x: clamp(cx - ob), y: clamp(cy + oa)};
        pts[4] = '{x: clamp(cx - ob), y: clamp(cy - oa)};
        pts[5] = '{x: clamp(cx - oa), y: clamp(cy - ob)};
        pts[6] = '{x: clamp(cx + oa), y: clamp(cy - ob)};
        pts[7] = '{x: clamp(cx + ob), y: clamp(cy - oa)};
    end

    always_ff @(posedge vif or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            finishing   <= 1'b0;
            group_valid <= 1'b0;
            arc_last    <= 1'b0;
            a_q         <= '0;
            b_q         <= '0;
            err_q       <= '0;
        end else begin
            arc_last <= 1'b0;
            if (arc_go) begin
                running   <= 1'b1;
                finishing <= 1'b0;
                a_q       <= '0;
                b_q       <= radius;
                err_q     <= 11'sd1 - $signed({3'b0, radius});
            end else if (step) begin
                a_q   <= a_next;
                b_q   <= b_next;
                err_q <= err_next;
                if (stop) begin
                    running   <= 1'b0;
                    finishing <= 1'b1;
                end
            end else if (finishing && !group_valid && ready) begin
                // last group drained out of the clipper
                finishing <= 1'b0;
                arc_last  <= 1'b1;
            end
            if (step) group_valid <= 1'b1;
            else if (ready) group_valid <= 1'b0;
        end
    end

    always_ff @(posedge vif) begin
        if (arc_go) begin
            ctr_q     <= arc_centre;
            group_arc <= clip_ref;
        end
        if (step) points <= pts;
    end

endmodule

// File: logic/reuleaux_ctrl.sv
`timescale 1ns/1ps

module reuleaux_ctrl (
    input  logic                        vif,
    input  logic                        rst_n,
    input  logic                        start,
    input  reuleaux_types_pkg::xcoord_t centre_x,
    input  reuleaux_types_pkg::ycoord_t centre_y,
    input  reuleaux_types_pkg::diam_t   diameter,
    input  logic                        clear_last,
    input  logic                        arc_last,
    output logic                        clear_go,
    output logic                        arc_go,
    output reuleaux_types_pkg::centre_t arc_centre,
    output reuleaux_types_pkg::diam_t   radius,
    output logic                        sel_clear,
    output logic                        done
);

    import reuleaux_types_pkg::*;
    import reuleaux_geom_pkg::*;

    ctrl_state_t        state;
    logic               start_q;
    logic               start_rise;
    logic               launch;
    diam_t              d_q;
    logic signed [14:0] cx_q;
    logic signed [14:0] cy_q;
    logic signed [14:0] h1_q;
    logic signed [14:0] h2_q;
    logic signed [14:0] half_d;
    centre_t            next_centre;

    assign start_rise = start && !start_q;
    assign half_d     = 15'(d_q >> 1);

    // next arc leaves on the end of the previous phase
    assign launch = (state == CLEAR && clear_last) ||
                    ((state == ARC_BOTTOM || state == ARC_LEFT) && arc_last);

    // request captured on the start edge only
    always_ff @(posedge vif) begin
        if (state == IDLE && start_rise) begin
            cx_q <= 15'(centre_x);
            cy_q <= 15'(centre_y);
            d_q  <= diameter;
            h1_q <= 15'(h1_of(diameter));
            h2_q <= 15'(h1_of(diameter)) << 1;
        end
    end

    // vertex for the arc about to start
    always_comb begin
        next_centre = '0;
        case (state)
            // bottom edge, traced around the top vertex
            CLEAR: begin
                next_centre.x   = cx_q;
                next_centre.y   = cy_q - h2_q;
                next_centre.arc = ARC_TOP_V;
            end
            // left edge, around the right vertex
            ARC_BOTTOM: begin
                next_centre.x   = cx_q + half_d;
                next_centre.y   = cy_q + h1_q;
                next_centre.arc = ARC_RIGHT_V;
            end
            // right edge, around the left vertex
            ARC_LEFT: begin
                next_centre.x   = cx_q - half_d;
                next_centre.y   = cy_q + h1_q;
                next_centre.arc = ARC_LEFT_V;
            end
            default: next_centre.arc = ARC_NONE;
        endcase
    end

    always_ff @(posedge vif) begin
        if (launch) begin
            arc_centre <= next_centre;
        end
    end

    always_ff @(posedge vif or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            start_q  <= 1'b0;
            clear_go <= 1'b0;
            arc_go   <= 1'b0;
        end else begin
            start_q  <= start;
            clear_go <= (state == IDLE) && start_rise;
            arc_go   <= launch;
            case (state)
                IDLE:       if (start_rise) state <= CLEAR;
                CLEAR:      if (clear_last) state <= ARC_BOTTOM;
                ARC_BOTTOM: if (arc_last) state <= ARC_LEFT;
                ARC_LEFT:   if (arc_last) state <= ARC_RIGHT;
                ARC_RIGHT:  if (arc_last) state <= DONE;
                // hold until the requester lets go
                DONE:       if (!start) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    assign radius    = d_q;
    assign sel_clear = (state == CLEAR);
    // falls with start, the state follows a cycle later
    assign done      = (state == DONE) && start;

endmodule

// File: logic/reuleaux_geom_pkg.sv
package reuleaux_geom_pkg;

    // visible frame
    localparam int SCREEN_W = 160;
    localparam int SCREEN_H = 120;

    // sqrt(3) in Q8
    localparam int SQRT3_Q8 = 443;
    // h1 = d * sqrt(3) / 6, so the Q8 product is divided by 6 * 256
    localparam int H1_DIV = 1536;

    // arc ids in centre_t.arc
    // 0 means no arc, every point is dropped
    localparam logic [1:0] ARC_NONE    = 2'd0;
    localparam logic [1:0] ARC_TOP_V   = 2'd1;
    localparam logic [1:0] ARC_LEFT_V  = 2'd2;
    localparam logic [1:0] ARC_RIGHT_V = 2'd3;

    // arc states are named after the edge they draw
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ARC_BOTTOM,
        ARC_LEFT,
        ARC_RIGHT,
        DONE
    } ctrl_state_t;

    // centroid to base distance, rounded to nearest
    function automatic logic [7:0] h1_of(input reuleaux_types_pkg::diam_t d);
        int unsigned prod;
        prod = int'(d) * SQRT3_Q8 + H1_DIV / 2;
        return 8'(prod / H1_DIV);
    endfunction

endpackage

// File: logic/reuleaux_top.sv
`timescale 1ns/1ps

module reuleaux_top (
    input  logic                        vif,
    input  logic                        rst_n,
    input  logic                        start,
    input  reuleaux_types_pkg::xcoord_t centre_x,
    input  reuleaux_types_pkg::ycoord_t centre_y,
    input  reuleaux_types_pkg::diam_t   diameter,
    input  reuleaux_types_pkg::colour_t colour,
    output reuleaux_types_pkg::pixel_t  pixel,
    output logic                        plot,
    output logic                        done
);

    import reuleaux_types_pkg::*;

    // control strobes
    logic          clear_go;
    logic          clear_last;
    logic          arc_go;
    logic          arc_last;
    logic          sel_clear;
    // tracer to clipper
    logic          ready;
    logic          group_valid;
    spoint_t [7:0] points;
    centre_t       group_arc;
    centre_t       arc_centre;
    diam_t         radius;
    // the two pixel streams
    pixel_t        clr_pixel;
    pixel_t        clip_pixel;
    logic          clr_plot;
    logic          clip_plot;

    reuleaux_ctrl u_ctrl (
        .vif        (vif),
        .rst_n      (rst_n),
        .start      (start),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .clear_last (clear_last),
        .arc_last   (arc_last),
        .clear_go   (clear_go),
        .arc_go     (arc_go),
        .arc_centre (arc_centre),
        .radius     (radius),
        .sel_clear  (sel_clear),
        .done       (done)
    );

    screen_clear u_clear (
        .vif        (vif),
        .rst_n      (rst_n),
        .clear_go   (clear_go),
        .pixel      (clr_pixel),
        .plot       (clr_plot),
        .clear_last (clear_last)
    );

    circle_octants u_octants (
        .vif         (vif),
        .rst_n       (rst_n),
        .arc_go      (arc_go),
        .arc_centre  (arc_centre),
        .radius      (radius),
        .ready       (ready),
        .group_valid (group_valid),
        .points      (points),
        .group_arc   (group_arc),
        .arc_last    (arc_last)
    );

    arc_clip u_clip (
        .vif         (vif),
        .rst_n       (rst_n),
        .group_valid (group_valid),
        .points      (points),
        .group_arc   (group_arc),
        .colour      (colour),
        .ready       (ready),
        .pixel       (clip_pixel),
        .plot        (clip_plot)
    );

    // clearer owns the output only during the clear phase
    assign {pixel, plot} = sel_clear ? {clr_pixel, clr_plot} : {clip_pixel, clip_plot};

endmodule

// File: logic/reuleaux_types_pkg.sv
package reuleaux_types_pkg;

    // screen column, 0 to 159
    typedef logic [7:0] xcoord_t;
    // screen row, 0 to 119
    typedef logic [6:0] ycoord_t;
    // 3-bit rgb
    typedef logic [2:0] colour_t;
    // triangle width, also the radius of every arc
    typedef logic [7:0] diam_t;
    // traced coordinate, may fall off screen
    typedef logic signed [9:0] scoord_t;

    // one pixel write toward the frame buffer
    typedef struct packed {
        xcoord_t x;
        ycoord_t y;
        colour_t colour;
    } pixel_t;

    // traced point before clipping
    typedef struct packed {
        scoord_t x;
        scoord_t y;
    } spoint_t;

    // arc centre or clip corner plus arc id
    // wide fields so vertices far off screen keep their sign
    typedef struct packed {
        logic signed [14:0] x;
        logic signed [14:0] y;
        logic [1:0]         arc;
        logic               spare;
    } centre_t;

endpackage

// File: logic/screen_clear.sv
`timescale 1ns/1ps

module screen_clear (
    input  logic                       vif,
    input  logic                       rst_n,
    input  logic                       clear_go,
    output reuleaux_types_pkg::pixel_t pixel,
    output logic                       plot,
    output logic                       clear_last
);

    import reuleaux_types_pkg::*;
    import reuleaux_geom_pkg::*;

    logic    active;
    logic    at_end;
    xcoord_t x_q;
    ycoord_t y_q;

    // bottom right corner
    assign at_end = (x_q == xcoord_t'(SCREEN_W - 1)) && (y_q == ycoord_t'(SCREEN_H - 1));

    // raster walk, x fastest
    always_ff @(posedge vif or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            x_q        <= '0;
            y_q        <= '0;
            plot       <= 1'b0;
            clear_last <= 1'b0;
        end else begin
            plot       <= active;
            clear_last <= active && at_end;
            if (clear_go) begin
                active <= 1'b1;
                x_q    <= '0;
                y_q    <= '0;
            end else if (active) begin
                if (x_q == xcoord_t'(SCREEN_W - 1)) begin
                    x_q <= '0;
                    if (at_end) active <= 1'b0;
                    else y_q <= y_q + 7'd1;
                end else begin
                    x_q <= x_q + 8'd1;
                end
            end
        end
    end

    // black pixel at the current position
    always_ff @(posedge vif) begin
        pixel <= '{x: x_q, y: y_q, colour: '0};
    end

endmodule

// File: verif/reuleaux_chk.sv
`timescale 1ns/1ps

module reuleaux_chk (
    input logic                       vif,
    input logic                       rst_n,
    input logic                       start,
    input logic                       plot,
    input logic                       done,
    input reuleaux_types_pkg::pixel_t pixel
);

    import reuleaux_geom_pkg::*;

    // outputs quiet while reset is held
    reset_quiet: assert property (@(posedge vif) !rst_n |-> (!plot && !done))
        else $error("plot or done active during reset");

    // done only for a live request and never during a write
    done_needs_start: assert property (@(posedge vif) disable iff (!rst_n)
        done |-> (start && !plot))
        else $error("done high without start or together with a pixel write");

    // every write lands inside the frame
    pixel_in_frame: assert property (@(posedge vif) disable iff (!rst_n)
        plot |-> (int'(pixel.x) < SCREEN_W) && (int'(pixel.y) < SCREEN_H))
        else $error("pixel written off screen at x=%0d y=%0d", pixel.x, pixel.y);

endmodule

bind reuleaux_top reuleaux_chk chk (
    .vif   (vif),
    .rst_n (rst_n),
    .start (start),
    .plot  (plot),
    .done  (done),
    .pixel (pixel)
);

// File: verif/reuleaux_tb.sv
`timescale 1ns/1ps

module reuleaux_tb;

    import reuleaux_types_pkg::*;
    import reuleaux_geom_pkg::*;

    // one drawing request and its hand-worked vertex offsets
    typedef struct packed {
        xcoord_t    cx;
        ycoord_t    cy;
        diam_t      d;
        colour_t    colour;
        logic [7:0] h1;
        logic [7:0] h2;
    } entry_t;

    localparam int N_ENTRIES   = 5;
    localparam int CLEAR_PLOTS = 19200;
    localparam int MAX_WAIT    = 16;

    // h1 = round(d * 443 / 1536), h2 = 2 * h1
    // third entry hangs off the top right corner
    entry_t tests [N_ENTRIES] = '{
        '{cx: 8'd80,  cy: 7'd60,  d: 8'd40,  colour: 3'd2, h1: 8'd12, h2: 8'd24},
        '{cx: 8'd40,  cy: 7'd70,  d: 8'd60,  colour: 3'd5, h1: 8'd17, h2: 8'd34},
        '{cx: 8'd150, cy: 7'd10,  d: 8'd50,  colour: 3'd7, h1: 8'd14, h2: 8'd28},
        '{cx: 8'd20,  cy: 7'd110, d: 8'd17,  colour: 3'd1, h1: 8'd5,  h2: 8'd10},
        '{cx: 8'd100, cy: 7'd64,  d: 8'd101, colour: 3'd4, h1: 8'd29, h2: 8'd58}
    };

    logic    vif;
    logic    rst_n;
    logic    start;
    xcoord_t centre_x;
    ycoord_t centre_y;
    diam_t   diameter;
    colour_t colour;
    pixel_t  pixel;
    logic    plot;
    logic    done;

    int       seed;
    int       cycle_count = 0;
    int       cycle_limit;
    int       cur;
    logic     drawing;
    int       plot_idx;
    int       clear_seen;
    // arc pixels straight across from each vertex
    int       end_x [3];
    int       end_y [3];
    logic [2:0] ends_seen;

    reuleaux_top dut (
        .vif      (vif),
        .rst_n    (rst_n),
        .start    (start),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .diameter (diameter),
        .colour   (colour),
        .pixel    (pixel),
        .plot     (plot),
        .done     (done)
    );

    initial begin
        vif = 1'b0;
        forever #2 vif = ~vif;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped at t=%0t", $time);
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // run length ceiling
    always @(posedge vif) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("simulation ran past its limit of %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // reset, then per entry the worst done latency and both random waits
    function automatic int run_limit();
        int total;
        total = 16 + 8;
        for (int i = 0; i < N_ENTRIES; i++) begin
            total += CLEAR_PLOTS + 24 * (int'(tests[i].d) + 2) + 100 + 2 * MAX_WAIT;
        end
        return total;
    endfunction

    function automatic int random_gap();
        return int'($unsigned($random(seed)) % MAX_WAIT);
    endfunction

    // pixel near some arc whose clip region it lies in
    function automatic logic on_outline(input entry_t e, input int x, input int y);
        int cx;
        int d;
        int base;
        int dx;
        int dy;
        int err;
        int vx [3];
        int vy [3];
        logic [2:0] region;
        logic hit;
        cx   = int'(e.cx);
        d    = int'(e.d);
        base = int'(e.cy) + int'(e.h1);
        // top, left, right vertex
        vx[0] = cx;
        vy[0] = int'(e.cy) - int'(e.h2);
        vx[1] = cx - d / 2;
        vy[1] = base;
        vx[2] = cx + d / 2;
        vy[2] = base;
        region[0] = (y >= base);
        region[1] = (x >= cx) && (y <= base);
        region[2] = (x <= cx) && (y <= base);
        hit = 1'b0;
        for (int v = 0; v < 3; v++) begin
            dx  = x - vx[v];
            dy  = y - vy[v];
            err = dx * dx + dy * dy - d * d;
            if (region[v] && err <= 2 * d + 1 && err >= -(2 * d + 1)) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic inspect_pixel();
        entry_t e;
        int x;
        int y;
        e = tests[cur];
        x = int'(pixel.x);
        y = int'(pixel.y);
        if (plot_idx < CLEAR_PLOTS) begin
            // black sweep, x fastest
            compare_value("pixel.x", x, plot_idx % SCREEN_W);
            compare_value("pixel.y", y, plot_idx / SCREEN_W);
            compare_value("pixel.colour", int'(pixel.colour), 0);
            clear_seen++;
        end else begin
            compare_value("pixel.colour", int'(pixel.colour), int'(e.colour));
            compare_value("pixel on screen", int'(x < SCREEN_W && y < SCREEN_H), 1);
            compare_value("pixel on outline", int'(on_outline(e, x, y)), 1);
            for (int k = 0; k < 3; k++) begin
                if (x == end_x[k] && y == end_y[k]) ends_seen[k] = 1'b1;
            end
        end
        plot_idx++;
    endtask

    // outputs are registered, so the falling edge sees them settled
    task automatic next_cycle();
        @(negedge vif);
        if (plot && !drawing) compare_value("plot", 1, 0);
        else if (plot) inspect_pixel();
    endtask

    task automatic load_entry(input int i);
        int d;
        int base;
        d    = int'(tests[i].d);
        base = int'(tests[i].cy) + int'(tests[i].h1);
        // bottom of the arc round the top vertex
        end_x[0] = int'(tests[i].cx);
        end_y[0] = int'(tests[i].cy) - int'(tests[i].h2) + d;
        // base line ends of the two side arcs
        end_x[1] = int'(tests[i].cx) - d / 2 + d;
        end_y[1] = base;
        end_x[2] = int'(tests[i].cx) + d / 2 - d;
        end_y[2] = base;
        for (int k = 0; k < 3; k++) begin
            // off-frame pixels are not expected
            ends_seen[k] = !(end_x[k] >= 0 && end_x[k] < SCREEN_W &&
                             end_y[k] >= 0 && end_y[k] < SCREEN_H);
        end
        cur        = i;
        plot_idx   = 0;
        clear_seen = 0;
        centre_x   = tests[i].cx;
        centre_y   = tests[i].cy;
        diameter   = tests[i].d;
        colour     = tests[i].colour;
        start      = 1'b1;
        drawing    = 1'b1;
    endtask

    initial begin
        int wait_cycles;
        int bound;
        seed        = 32'h8b9afed1;
        cycle_limit = run_limit();
        rst_n       = 1'b0;
        start       = 1'b0;
        centre_x    = '0;
        centre_y    = '0;
        diameter    = '0;
        colour      = '0;
        drawing     = 1'b0;
        cur         = 0;
        repeat (16) @(negedge vif);
        rst_n = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            // idle gap, nothing drawn and done low
            repeat (1 + random_gap()) begin
                next_cycle();
                compare_value("done", int'(done), 0);
            end
            load_entry(i);
            bound       = CLEAR_PLOTS + 24 * (int'(tests[i].d) + 2) + 100;
            wait_cycles = 0;
            while (!done) begin
                next_cycle();
                wait_cycles++;
                if (wait_cycles > bound) begin
                    $display("done not seen within %0d cycles of start, entry %0d", bound, i);
                    abort_run();
                end
            end
            // no writes once done is up
            drawing = 1'b0;
            compare_value("clear plot count", clear_seen, CLEAR_PLOTS);
            for (int k = 0; k < 3; k++) begin
                compare_value($sformatf("end pixel %0d plotted", k), int'(ends_seen[k]), 1);
            end
            // done held for as long as start is
            repeat (random_gap()) begin
                next_cycle();
                compare_value("done", int'(done), 1);
            end
            start = 1'b0;
        end
        repeat (4) begin
            next_cycle();
            compare_value("done", int'(done), 0);
        end
        $display("Everything OK");
        $finish;
    end

endmodule
